//--- project.f
design/cpu_pkg.sv
design/display_pkg.sv
design/alu.sv
design/register_file.sv
design/program_memory.sv
design/segment_display.sv
design/cpu_control.sv
design/cpu_top.sv
testbench/cpu_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --top-module cpu_tb -f project.f -o cpu_tb_sim || exit 1
out=$(./obj_dir/cpu_tb_sim)
echo "$out"
echo "$out" | grep -qx "Test passed" && echo "Simulation OK" || { echo "Simulation FAILED"; exit 1; }

//--- testbench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;
	import display_pkg::*;

	localparam int addr_bits = 10;
	localparam int tick_cycles = 4;
	localparam int scan_cycles = 8;
	localparam int top_addr = (1 << addr_bits) - 1;
	localparam int num_tests = 11;
	localparam int max_words = 8;
	localparam int watchdog_margin = 200;
	localparam logic [31:0] random_seed = 32'hb90d_963d;

	logic clk;
	logic wait_reset;
	logic run;
	logic [addr_bits-1:0] host_addr;
	logic [word_width-1:0] host_wdata;
	logic host_we;
	logic [word_width-1:0] host_rdata;
	logic halted;
	logic [segment_bits-1:0] seven_segment;
	logic [digit_count-1:0] digit_enable;
	logic [3:0] leds;

	// Stimulus table with one row per program
	logic [15:0] prog [num_tests][max_words];
	int prog_len [num_tests];
	logic [addr_bits-1:0] opnd_addr [num_tests];
	logic [15:0] opnd_value [num_tests];
	logic [addr_bits-1:0] res_addr [num_tests];
	logic [15:0] exp_result [num_tests];
	logic [15:0] exp_opnd [num_tests];  // Operand word after the run
	int wait_ms [num_tests];
	string test_name [num_tests];

	int row_count;
	logic table_ready;
	logic [31:0] lcg_state;
	int error_count;
	int tests_run;
	int tests_failed;

	cpu_top #(
		.addr_bits(addr_bits),
		.tick_cycles(tick_cycles),
		.scan_cycles(scan_cycles)
	) cpu_top_inst (
		.clk(clk),
		.wait_reset(wait_reset),
		.run(run),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_we(host_we),
		.host_rdata(host_rdata),
		.halted(halted),
		.seven_segment(seven_segment),
		.digit_enable(digit_enable),
		.leds(leds)
	);

	always #4 clk = ~clk;

	function logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [15:0] encode_instr(opcode_t op, logic [3:0] rd, logic [7:0] low);
		return {op, rd, low};
	endfunction

	// Reference rules for the register ops
	function automatic logic [15:0] expected_alu_result(opcode_t op, logic [15:0] a,
		logic [15:0] b);
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			OP_SHL: return a << b[3:0];
			default: return 16'h0;
		endcase
	endfunction

	task automatic advance_clock();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected)
		begin
			$display("error: %s is %h, expected %h", name, actual, expected);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (error_count != errors_before)
		begin
			tests_failed++;
			$display("%s: FAILED", name);
		end
		else
			$display("%s: ok", name);
	endtask

	////////////////////////////////////////
	// Host port access
	////////////////////////////////////////
	task automatic write_word(input logic [addr_bits-1:0] addr, input logic [15:0] data);
		host_addr = addr;
		host_wdata = data;
		host_we = 1'b1;
		advance_clock();
		host_we = 1'b0;
	endtask

	task automatic read_word(input logic [addr_bits-1:0] addr, output logic [15:0] data);
		host_addr = addr;
		advance_clock();  // One cycle read latency
		data = host_rdata;
	endtask

	task automatic append_word(input logic [15:0] word);
		prog[row_count][prog_len[row_count]] = word;
		prog_len[row_count]++;
	endtask

	task automatic finish_row(input string name, input logic [addr_bits-1:0] oa,
		input logic [15:0] ov, input logic [addr_bits-1:0] ra, input logic [15:0] er,
		input logic [15:0] eo, input int wms);
		test_name[row_count] = name;
		opnd_addr[row_count] = oa;
		opnd_value[row_count] = ov;
		res_addr[row_count] = ra;
		exp_result[row_count] = er;
		exp_opnd[row_count] = eo;
		wait_ms[row_count] = wms;
		row_count++;
	endtask

	task automatic build_table();
		opcode_t arith_ops [6];
		logic [31:0] r;
		logic [15:0] a;
		logic [7:0] b8;
		logic [addr_bits-1:0] oa;
		logic [addr_bits-1:0] ra;
		logic [31:0] sum;
		logic [15:0] expected;
		arith_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL};
		row_count = 0;
		for (int i = 0; i < num_tests; i++)
			prog_len[i] = 0;
		// Register ops on a loaded word and an 8-bit immediate
		for (int k = 0; k < 6; k++)
		begin
			r = next_random();
			a = r[15:0];
			b8 = r[23:16];
			oa = addr_bits'(32 + k);
			ra = addr_bits'(64 + k);
			append_word(encode_instr(OP_MOVI, 4'd1, oa[7:0]));
			append_word(encode_instr(OP_LOAD, 4'd2, 8'd1));
			append_word(encode_instr(OP_MOVI, 4'd3, b8));
			append_word(encode_instr(arith_ops[k], 4'd2, 8'd3));
			append_word(encode_instr(OP_MOVI, 4'd4, ra[7:0]));
			append_word(encode_instr(OP_STORE, 4'd2, 8'd4));
			append_word(encode_instr(OP_HALT, 4'd0, 8'd0));
			finish_row(arith_ops[k].name(), oa, a, ra,
				expected_alu_result(arith_ops[k], a, {8'h0, b8}), a, 0);
		end
		// 32-bit add with the low word stored over the operand and the high word as result
		r = next_random();
		a = r[15:0] | 16'h0080;
		b8 = r[23:16] | 8'h80;  // Negative immediate so the low add always carries
		oa = addr_bits'(48);
		ra = addr_bits'(80);
		sum = {16'(oa), a} + {16'(oa), {8{b8[7]}}, b8};
		append_word(encode_instr(OP_MOVI, 4'd1, oa[7:0]));
		append_word(encode_instr(OP_LOAD, 4'd2, 8'd1));
		append_word(encode_instr(OP_ADDI, 4'd2, b8));
		append_word(encode_instr(OP_STORE, 4'd2, 8'd1));
		append_word(encode_instr(OP_ADDC, 4'd1, 8'd1));
		append_word(encode_instr(OP_MOVI, 4'd4, ra[7:0]));
		append_word(encode_instr(OP_STORE, 4'd1, 8'd4));
		append_word(encode_instr(OP_HALT, 4'd0, 8'd0));
		finish_row("carry_chain", oa, a, ra, sum[31:16], sum[15:0], 0);
		// JMP to top_addr - 6 over a store into the operand word
		r = next_random();
		oa = addr_bits'(52);
		ra = addr_bits'(84);
		append_word(encode_instr(OP_MOVI, 4'd1, 8'h00));
		append_word(encode_instr(OP_ADDI, 4'd1, 8'hf9));
		append_word(encode_instr(OP_MOVI, 4'd2, oa[7:0]));
		append_word(encode_instr(OP_MOVI, 4'd4, ra[7:0]));
		append_word(encode_instr(OP_JMP, 4'd1, 8'h00));
		append_word(encode_instr(OP_STORE, 4'd4, 8'd2));  // Skipped
		append_word(encode_instr(OP_STORE, 4'd1, 8'd4));
		append_word(encode_instr(OP_HALT, 4'd0, 8'd0));
		finish_row("jmp", oa, r[15:0], ra, 16'hfff9, r[15:0], 0);
		// CMP then BLT where only the fall-through path stores b
		for (int k = 0; k < 2; k++)
		begin
			r = next_random();
			a = (k == 0) ? (r[15:0] | 16'h8000) : ((r[15:0] & 16'h7fff) | 16'h0100);
			b8 = r[23:16] | 8'h01;
			oa = addr_bits'(56 + k);
			ra = addr_bits'(88 + k);
			expected = ($signed(a) < $signed({8'h0, b8})) ? 16'h0 : {8'h0, b8};
			append_word(encode_instr(OP_MOVI, 4'd1, oa[7:0]));
			append_word(encode_instr(OP_LOAD, 4'd2, 8'd1));
			append_word(encode_instr(OP_MOVI, 4'd3, b8));
			append_word(encode_instr(OP_MOVI, 4'd4, ra[7:0]));
			append_word(encode_instr(OP_CMP, 4'd2, 8'd3));
			append_word(encode_instr(OP_BLT, 4'd0, 8'd2));  // Lands on HALT
			append_word(encode_instr(OP_STORE, 4'd3, 8'd4));
			append_word(encode_instr(OP_HALT, 4'd0, 8'd0));
			finish_row((k == 0) ? "blt_taken" : "blt_not_taken", oa, a, ra, expected, a, 0);
		end
		r = next_random();
		oa = addr_bits'(60);
		ra = addr_bits'(92);
		append_word(encode_instr(OP_MOVI, 4'd4, ra[7:0]));
		append_word(encode_instr(OP_MOVI, 4'd3, r[23:16]));
		append_word(encode_instr(OP_WAIT, 4'd0, 8'd5));
		append_word(encode_instr(OP_STORE, 4'd3, 8'd4));
		append_word(encode_instr(OP_HALT, 4'd0, 8'd0));
		finish_row("wait", oa, r[15:0], ra, {8'h0, r[23:16]}, r[15:0], 5);
	endtask

	////////////////////////////////////////
	// Test procedures
	////////////////////////////////////////
	task automatic run_row(input int i);
		int cycles;
		int errors_before;
		logic [15:0] word;
		errors_before = error_count;
		write_word(res_addr[i], 16'h0);
		write_word(opnd_addr[i], opnd_value[i]);
		for (int j = 0; j < prog_len[i]; j++)
			write_word(addr_bits'(top_addr - j), prog[i][j]);
		run = 1'b1;
		cycles = 0;
		while (!halted)
		begin
			advance_clock();
			cycles++;
		end
		if (cycles < wait_ms[i] * tick_cycles)
		begin
			$display("%s halted after %0d cycles, sooner than its WAIT allows", test_name[i],
				cycles);
			error_count++;
		end
		run = 1'b0;
		advance_clock();
		check_value("halted", {15'h0, halted}, 16'h0);
		read_word(res_addr[i], word);
		check_value("result", word, exp_result[i]);
		read_word(opnd_addr[i], word);
		check_value("operand word", word, exp_opnd[i]);
		report_test(test_name[i], errors_before);
	endtask

	task automatic check_reset_idle();
		int errors_before;
		logic [31:0] r;
		logic [15:0] word;
		errors_before = error_count;
		check_value("halted", {15'h0, halted}, 16'h0);
		r = next_random();
		write_word(addr_bits'(16), r[15:0]);
		read_word(addr_bits'(16), word);
		check_value("host_rdata", word, r[15:0]);
		report_test("reset_idle", errors_before);
	endtask

	task automatic check_display();
		int errors_before;
		int lit;
		logic [31:0] r;
		logic [15:0] value;
		logic [15:0] rest;
		logic [3:0] digit;
		logic [segment_bits-1:0] seen [digit_count];
		logic [digit_count-1:0] seen_mask;
		errors_before = error_count;
		r = next_random();
		value = r[15:0];
		seen_mask = '0;
		write_word(addr_bits'(96), value);
		host_addr = addr_bits'(96);
		advance_clock();
		advance_clock();
		repeat (digit_count * scan_cycles)
		begin
			lit = -1;
			for (int i = 0; i < digit_count; i++)
				if (digit_enable == ~(digit_count'(1) << i))
					lit = i;
			if (lit < 0)
			begin
				$display("digit_enable %b does not select exactly one digit", digit_enable);
				error_count++;
			end
			else
			begin
				seen[lit] = seven_segment;
				seen_mask[lit] = 1'b1;
			end
			advance_clock();
		end
		rest = value;
		for (int i = 0; i < digit_count; i++)
		begin
			digit = 4'(rest % 16'd10);
			if (!seen_mask[i])
			begin
				$display("digit %0d was never enabled during a full scan", i);
				error_count++;
			end
			else
				check_value($sformatf("seven_segment digit %0d", i), {9'h0, seen[i]},
					{9'h0, segment_pattern(digit)});
			rest = rest / 16'd10;
		end
		check_value("leds", {12'h0, leds}, rest);  // Ten-thousands left over
		report_test("display", errors_before);
	endtask

	initial
	begin
		clk = 1'b0;
		wait_reset = 1'b1;
		run = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		host_we = 1'b0;
		lcg_state = random_seed;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		table_ready = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		wait_reset = 1'b0;
		check_reset_idle();
		for (int i = 0; i < num_tests; i++)
			run_row(i);
		check_display();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Watchdog sized from the table
	initial
	begin
		int limit;
		wait (table_ready);
		limit = watchdog_margin;
		for (int i = 0; i < num_tests; i++)
			limit += 20 * prog_len[i] + wait_ms[i] * tick_cycles;
		repeat (limit) @(posedge clk);
		$display("Watchdog expired after %0d cycles, a program never reached HALT", limit);
		$display("Test failed");
		$finish;
	end

endmodule

//--- design/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
	parameter int addr_bits = 10,
	parameter int tick_cycles = 166667,
	parameter int scan_cycles = 1024
) (
	input  logic clk,
	input  logic wait_reset,
	input  logic run,
	input  logic [addr_bits-1:0] host_addr,
	input  logic [cpu_pkg::word_width-1:0] host_wdata,
	input  logic host_we,
	output logic [cpu_pkg::word_width-1:0] host_rdata,
	output logic halted,
	output logic [display_pkg::segment_bits-1:0] seven_segment,
	output logic [display_pkg::digit_count-1:0] digit_enable,
	output logic [3:0] leds
);
	import cpu_pkg::*;

	logic [word_width-1:0] instr;
	logic [addr_bits-1:0] pc;
	logic [addr_bits-1:0] mem_addr;
	logic mem_addr_sel;
	logic mem_we;
	logic reg_we;
	logic wb_sel;
	logic alu_op_sel;
	logic [word_width-1:0] alu_ctrl_word;
	logic [reg_sel_bits-1:0] rd_sel;
	logic [reg_sel_bits-1:0] ra_sel;
	logic [reg_sel_bits-1:0] rb_sel;
	logic carry_saved;
	logic [word_width-1:0] reg_a;
	logic [word_width-1:0] reg_b;
	logic [word_width-1:0] alu_instr;
	logic [word_width-1:0] alu_result;
	logic [flag_count-1:0] alu_flags;
	logic [word_width-1:0] wb_data;

	////////////////////////////////////////
	// Datapath muxes
	////////////////////////////////////////
	assign mem_addr = mem_addr_sel ? reg_b[addr_bits-1:0] : pc;
	assign wb_data = wb_sel ? instr : alu_result;  // Port A data on LOAD
	assign alu_instr = alu_op_sel ? alu_ctrl_word : instr;

	cpu_control #(
		.addr_bits(addr_bits),
		.tick_cycles(tick_cycles)
	) cpu_control_inst (
		.clk(clk),
		.wait_reset(wait_reset),
		.run(run),
		.instr(instr),
		.flags(alu_flags),
		.alu_result(alu_result),
		.halted(halted),
		.pc(pc),
		.mem_addr_sel(mem_addr_sel),
		.mem_we(mem_we),
		.reg_we(reg_we),
		.wb_sel(wb_sel),
		.alu_op_sel(alu_op_sel),
		.alu_ctrl_word(alu_ctrl_word),
		.rd_sel(rd_sel),
		.ra_sel(ra_sel),
		.rb_sel(rb_sel),
		.carry_saved(carry_saved)
	);

	alu alu_inst (
		.a(reg_a),
		.b(reg_b),
		.instr(alu_instr),
		.carry_in(carry_saved),
		.result(alu_result),
		.flags(alu_flags)
	);

	register_file register_file_inst (
		.clk(clk),
		.wait_reset(wait_reset),
		.we(reg_we),
		.wr_sel(rd_sel),
		.rd_a_sel(ra_sel),
		.rd_b_sel(rb_sel),
		.wr_data(wb_data),
		.rd_a(reg_a),
		.rd_b(reg_b)
	);

	// Host port B writes only while stopped
	program_memory #(
		.addr_bits(addr_bits)
	) program_memory_inst (
		.clk(clk),
		.a_addr(mem_addr),
		.b_addr(host_addr),
		.a_wdata(alu_result),
		.b_wdata(host_wdata),
		.a_we(mem_we),
		.b_we(host_we && !run),
		.a_rdata(instr),
		.b_rdata(host_rdata)
	);

	segment_display #(
		.scan_cycles(scan_cycles)
	) segment_display_inst (
		.clk(clk),
		.wait_reset(wait_reset),
		.value(host_rdata),
		.seven_segment(seven_segment),
		.digit_enable(digit_enable),
		.leds(leds)
	);

endmodule

//--- design/cpu_control.sv
`timescale 1ns/1ps

module cpu_control #(
	parameter int addr_bits = 10,
	parameter int tick_cycles = 166667
) (
	input  logic clk,
	input  logic wait_reset,
	input  logic run,
	input  logic [cpu_pkg::word_width-1:0] instr,
	input  logic [cpu_pkg::flag_count-1:0] flags,
	input  logic [cpu_pkg::word_width-1:0] alu_result,
	output logic halted,
	output logic [addr_bits-1:0] pc,
	output logic mem_addr_sel,
	output logic mem_we,
	output logic reg_we,
	output logic wb_sel,
	output logic alu_op_sel,
	output logic [cpu_pkg::word_width-1:0] alu_ctrl_word,
	output logic [cpu_pkg::reg_sel_bits-1:0] rd_sel,
	output logic [cpu_pkg::reg_sel_bits-1:0] ra_sel,
	output logic [cpu_pkg::reg_sel_bits-1:0] rb_sel,
	output logic carry_saved
);
	import cpu_pkg::*;

	localparam int prescale_bits = $clog2(tick_cycles + 1);

	state_t state;
	opcode_t fetched_op;
	opcode_t ir_op;
	logic [word_width-1:0] ir;  // Held past DECODE, LOAD reuses port A
	logic [flag_count-1:0] saved_flags;
	logic [prescale_bits-1:0] prescale;
	logic [imm12_bits-1:0] ms_count;
	logic wait_done;

	assign fetched_op = opcode_t'(instr[opcode_lsb +: opcode_bits]);
	assign ir_op = opcode_t'(ir[opcode_lsb +: opcode_bits]);
	assign wait_done = (state == WAIT_TICK) && (ms_count == ir[imm12_bits-1:0]);

	////////////////////////////////////////
	// State sequencing
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (wait_reset || !run)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE: state <= FETCH;
				FETCH: state <= DECODE;
				DECODE:
				begin
					case (fetched_op)
						OP_JMP: state <= JUMP;
						OP_LOAD: state <= LOAD_ADDR;
						OP_STORE: state <= STORE;
						OP_WAIT: state <= WAIT_TICK;
						OP_BLT: state <= BRANCH;
						OP_HALT: state <= HALTED;
						default: state <= EXEC;  // Register and immediate ops
					endcase
				end
				LOAD_ADDR: state <= LOAD_WB;
				WAIT_TICK: state <= wait_done ? FETCH : WAIT_TICK;
				HALTED: state <= HALTED;
				default: state <= FETCH;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == DECODE)
			ir <= instr;
	end

	// PC counts down from the top of memory
	always_ff @(posedge clk)
	begin
		if (wait_reset || state == IDLE)
		begin
			pc <= '1;
			saved_flags <= '0;
		end
		else
		begin
			case (state)
				EXEC, LOAD_WB, STORE: pc <= pc - 1'b1;
				JUMP: pc <= alu_result[addr_bits-1:0];  // rd passed through the ALU
				BRANCH:
					pc <= saved_flags[flag_less] ? pc - addr_bits'(ir[imm8_bits-1:0])
						: pc - 1'b1;
				WAIT_TICK:
				begin
					if (wait_done)
						pc <= pc - 1'b1;
				end
				default: pc <= pc;
			endcase
			if (state == EXEC && ir_op != OP_MOVI)
				saved_flags <= flags;
		end
	end

	////////////////////////////////////////
	// Millisecond timer
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (wait_reset || wait_done || state == IDLE)
		begin
			prescale <= '0;
			ms_count <= '0;
		end
		else if (state == WAIT_TICK)
		begin
			if (prescale == prescale_bits'(tick_cycles - 1))
			begin
				prescale <= '0;
				ms_count <= ms_count + 1'b1;
			end
			else
				prescale <= prescale + 1'b1;
		end
	end

	// Datapath selects from the state
	always_comb
	begin
		mem_addr_sel = 1'b0;
		mem_we = 1'b0;
		reg_we = 1'b0;
		wb_sel = 1'b0;
		alu_op_sel = 1'b0;
		case (state)
			EXEC: reg_we = (ir_op != OP_CMP);  // CMP only sets flags
			JUMP: alu_op_sel = 1'b1;
			LOAD_ADDR: mem_addr_sel = 1'b1;
			LOAD_WB:
			begin
				wb_sel = 1'b1;
				reg_we = 1'b1;
			end
			STORE:
			begin
				mem_addr_sel = 1'b1;
				mem_we = 1'b1;
				alu_op_sel = 1'b1;
			end
			default: mem_we = 1'b0;
		endcase
	end

	assign halted = (state == HALTED);
	assign alu_ctrl_word = {OP_ADDI, ir[rd_lsb +: reg_sel_bits], {imm8_bits{1'b0}}};
	assign rd_sel = ir[rd_lsb +: reg_sel_bits];
	assign ra_sel = ir[rd_lsb +: reg_sel_bits];  // a operand is rd
	assign rb_sel = ir[rb_lsb +: reg_sel_bits];
	assign carry_saved = saved_flags[flag_carry];

endmodule

//--- design/segment_display.sv
`timescale 1ns/1ps

module segment_display #(
	parameter int scan_cycles = 1024
) (
	input  logic clk,
	input  logic wait_reset,
	input  logic [15:0] value,
	output logic [display_pkg::segment_bits-1:0] seven_segment,
	output logic [display_pkg::digit_count-1:0] digit_enable,
	output logic [3:0] leds
);
	import display_pkg::*;

	localparam int scan_bits = $clog2(scan_cycles + 1);
	localparam int sel_bits = $clog2(digit_count);

	logic [3:0] digits [digit_count];
	logic [scan_bits-1:0] scan_count;
	logic [sel_bits-1:0] digit_sel;

	// Decimal split of the low four digits
	always_comb
	begin
		digits[0] = 4'(value % 16'd10);
		digits[1] = 4'((value / 16'd10) % 16'd10);
		digits[2] = 4'((value / 16'd100) % 16'd10);
		digits[3] = 4'((value / 16'd1000) % 16'd10);
	end

	assign leds = 4'(value / 16'd10000);  // At most 6

	////////////////////////////////////////
	// Digit scan
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (wait_reset)
		begin
			scan_count <= '0;
			digit_sel <= '0;
		end
		else if (scan_count == scan_bits'(scan_cycles - 1))
		begin
			scan_count <= '0;
			digit_sel <= digit_sel + 1'b1;  // Wraps after the top digit
		end
		else
			scan_count <= scan_count + 1'b1;
	end

	assign digit_enable = ~(digit_count'(1) << digit_sel);
	assign seven_segment = segment_pattern(digits[digit_sel]);

endmodule

//--- design/program_memory.sv
`timescale 1ns/1ps

module program_memory #(
	parameter int addr_bits = 10
) (
	input  logic clk,
	input  logic [addr_bits-1:0] a_addr,
	input  logic [addr_bits-1:0] b_addr,
	input  logic [cpu_pkg::word_width-1:0] a_wdata,
	input  logic [cpu_pkg::word_width-1:0] b_wdata,
	input  logic a_we,
	input  logic b_we,
	output logic [cpu_pkg::word_width-1:0] a_rdata,
	output logic [cpu_pkg::word_width-1:0] b_rdata
);
	import cpu_pkg::*;

	logic [word_width-1:0] mem [1 << addr_bits];

	// Both ports in one process, reads see the old word
	always_ff @(posedge clk)
	begin
		if (a_we)
			mem[a_addr] <= a_wdata;
		if (b_we)
			mem[b_addr] <= b_wdata;  // Host wins a same-address collision
		a_rdata <= mem[a_addr];
		b_rdata <= mem[b_addr];
	end

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic clk,
	input  logic wait_reset,
	input  logic we,
	input  logic [cpu_pkg::reg_sel_bits-1:0] wr_sel,
	input  logic [cpu_pkg::reg_sel_bits-1:0] rd_a_sel,
	input  logic [cpu_pkg::reg_sel_bits-1:0] rd_b_sel,
	input  logic [cpu_pkg::word_width-1:0] wr_data,
	output logic [cpu_pkg::word_width-1:0] rd_a,
	output logic [cpu_pkg::word_width-1:0] rd_b
);
	import cpu_pkg::*;

	logic [word_width-1:0] regs [1 << reg_sel_bits];

	always_ff @(posedge clk)
	begin
		if (wait_reset)
		begin
			for (int i = 0; i < (1 << reg_sel_bits); i++)
				regs[i] <= '0;
		end
		else if (we)
			regs[wr_sel] <= wr_data;
	end

	assign rd_a = regs[rd_a_sel];
	assign rd_b = regs[rd_b_sel];

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [cpu_pkg::word_width-1:0] a,
	input  logic [cpu_pkg::word_width-1:0] b,
	input  logic [cpu_pkg::word_width-1:0] instr,
	input  logic carry_in,
	output logic [cpu_pkg::word_width-1:0] result,
	output logic [cpu_pkg::flag_count-1:0] flags
);
	import cpu_pkg::*;

	localparam int sum_bits = word_width + 1;
	localparam int shamt_bits = $clog2(word_width);
	localparam int msb = word_width - 1;

	opcode_t op;
	logic [word_width-1:0] operand;
	logic cin;
	logic carry;
	logic overflow;

	assign op = opcode_t'(instr[opcode_lsb +: opcode_bits]);
	// ADDI takes the sign-extended immediate
	assign operand = (op == OP_ADDI)
		? {{(word_width - imm8_bits){instr[imm8_bits-1]}}, instr[imm8_bits-1:0]} : b;
	assign cin = (op == OP_ADDC) ? carry_in : 1'b0;

	always_comb
	begin
		carry = 1'b0;
		overflow = 1'b0;
		case (op)
			OP_ADD, OP_ADDC, OP_ADDI:
			begin
				{carry, result} = {1'b0, a} + {1'b0, operand} + sum_bits'(cin);
				overflow = (a[msb] == operand[msb]) && (result[msb] != a[msb]);
			end
			OP_SUB, OP_CMP:
			begin
				{carry, result} = {1'b0, a} - {1'b0, b};  // Carry holds the borrow
				overflow = (a[msb] != b[msb]) && (result[msb] != a[msb]);
			end
			OP_AND: result = a & b;
			OP_OR: result = a | b;
			OP_XOR: result = a ^ b;
			OP_SHL: result = a << b[shamt_bits-1:0];
			OP_MOVI: result = {{(word_width - imm8_bits){1'b0}}, instr[imm8_bits-1:0]};
			default: result = a;
		endcase
	end

	always_comb
	begin
		flags = '0;
		flags[flag_carry] = carry;
		flags[flag_zero] = (result == '0);
		flags[flag_negative] = result[msb];
		flags[flag_overflow] = overflow;
		flags[flag_less] = $signed(a) < $signed(b);
	end

endmodule

//--- design/display_pkg.sv
package display_pkg;

	localparam int digit_count = 4;
	localparam int segment_bits = 7;

	// Segments g..a, a zero bit lights the segment
	function automatic logic [segment_bits-1:0] segment_pattern(input logic [3:0] digit);
		case (digit)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0010000;
			default: return 7'b1111111;  // Blank
		endcase
	endfunction

endpackage

//--- design/cpu_pkg.sv
package cpu_pkg;

	localparam int word_width = 16;
	localparam int opcode_bits = 4;
	localparam int reg_sel_bits = 4;
	localparam int imm8_bits = 8;
	localparam int imm12_bits = 12;

	// Field positions in the instruction word
	localparam int opcode_lsb = 12;
	localparam int rd_lsb = 8;
	localparam int rb_lsb = 0;  // Immediates also start at bit 0

	localparam int flag_count = 5;
	localparam int flag_carry = 0;
	localparam int flag_zero = 1;
	localparam int flag_negative = 2;
	localparam int flag_overflow = 3;
	localparam int flag_less = 4;  // Signed a < b

	typedef enum logic [opcode_bits-1:0] {
		OP_ADD = 4'h0, OP_ADDC = 4'h1, OP_SUB = 4'h2, OP_AND = 4'h3,
		OP_OR = 4'h4, OP_XOR = 4'h5, OP_SHL = 4'h6, OP_CMP = 4'h7,
		OP_ADDI = 4'h8, OP_MOVI = 4'h9,
		OP_JMP = 4'ha, OP_LOAD = 4'hb, OP_STORE = 4'hc, OP_WAIT = 4'hd,
		OP_BLT = 4'he, OP_HALT = 4'hf
	} opcode_t;

	typedef enum logic [3:0] {
		IDLE, FETCH, DECODE, EXEC, JUMP, LOAD_ADDR, LOAD_WB,
		STORE, WAIT_TICK, BRANCH, HALTED
	} state_t;

endpackage
